// ==== l0TribeBoard.f ====
src/tribePkg.sv
src/controlDecoder.sv
src/refillRequester.sv
src/burstMarkerDispatcher.sv
src/softResetSequencer.sv
src/l0TribeBoard.sv
bench/l0TribeBoardTb.sv

// ==== runSim.sh ====
#!/usr/bin/env bash
# Builds the board controller testbench with Verilator, runs it and checks the result

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
   --top-module l0TribeBoardTb \
   -f l0TribeBoard.f \
   -o l0TribeBoardSim \
   || { echo "Build failed"; exit 1; }

simOutput=$(./obj_dir/l0TribeBoardSim 2>&1)
echo "$simOutput"

echo "$simOutput" | grep -q "All checks passed" \
   && echo "Simulation result: pass" \
   || { echo "Simulation result: fail"; exit 1; }

// ==== bench/l0TribeBoardTb.sv ====
// Testbench for the board controller top level; run through runSim.sh or any Verilator build
module l0TribeBoardTb
   import tribePkg::*;
;

   localparam int refillThreshold = 128;
   localparam int markerCycles    = 4;
   localparam int holdOffCycles   = 20;
   localparam int pulseCycles     = 30;
   localparam int resetCycles     = 5;
   localparam int settleCycles    = 4;    // Row wait before compare
   localparam int seqLimit        = 200;  // Upper bound on one reset phase
   localparam int randomSeed      = 97649;

   logic        OSC_50_BANK6 = 1'b0;
   logic        reset;
   ctrlWord_t   ctrlWord;
   fillLevels_t fillLevels;
   irqVector_t  detectorUnderInit;
   irqVector_t  interrupt;
   logic        ECRST;
   logic        BCRST;
   logic        softResetN;
   logic [7:0]  LED;

   // Stimulus table, one entry per row in each queue
   string       rowName[$];
   ctrlWord_t   rowCtrl[$];
   fillLevels_t rowFill[$];
   irqVector_t  rowDet[$];
   irqVector_t  rowIrq[$];
   logic [7:0]  rowLed[$];

   l0TribeBoard #(
      .RefillThreshold  (refillThreshold),
      .MarkerCycles     (markerCycles),
      .HoldOffCycles    (holdOffCycles),
      .ResetPulseCycles (pulseCycles)
   ) l0TribeBoard_i (
      .OSC_50_BANK6      (OSC_50_BANK6),
      .reset             (reset),
      .ctrlWord          (ctrlWord),
      .fillLevels        (fillLevels),
      .detectorUnderInit (detectorUnderInit),
      .interrupt         (interrupt),
      .ECRST             (ECRST),
      .BCRST             (BCRST),
      .softResetN        (softResetN),
      .LED               (LED)
   );

   always #2 OSC_50_BANK6 = ~OSC_50_BANK6;  // Period 4

   //========================================
   // Failure reporting and compares
   //========================================
   task automatic reportFailure(string what);
      $display("%s", what);
      $display("Checks failed");
      $fatal(1, "Stopped at the first error");
   endtask

   task automatic checkIrq(string name, irqVector_t expected, irqVector_t actual);
      if (actual !== expected)
         reportFailure($sformatf("MISMATCH %s: expected %h, actual %h", name, expected, actual));
   endtask

   task automatic checkMarkers(string name, markerPair_t expected, markerPair_t actual);
      if (actual !== expected)
         reportFailure($sformatf("MISMATCH %s: expected %b, actual %b", name, expected, actual));
   endtask

   task automatic checkLevel(string name, logic [7:0] expected, logic [7:0] actual);
      if (actual !== expected)
         reportFailure($sformatf("MISMATCH %s: expected %h, actual %h", name, expected, actual));
   endtask

   task automatic checkCount(string name, int expected, int actual);
      if (actual != expected)
         reportFailure($sformatf("MISMATCH %s: expected %0d, actual %0d", name, expected, actual));
   endtask

   function automatic markerPair_t markerPins();
      markerPair_t seen;
      seen.ecrst = ECRST;
      seen.bcrst = BCRST;
      return seen;
   endfunction

   //========================================
   // Expected values and table
   //========================================
   // Refill request per buffer in a burst, detector flags otherwise
   function automatic irqVector_t expectIrq(ctrlWord_t ctrl, fillLevels_t fill, irqVector_t det);
      irqVector_t result;
      if (ctrl[burstBit]) begin
         result = '0;
         for (int p = 0; p < numPorts; p++) begin
            result[p] = (int'(fill[p]) < refillThreshold);
         end
      end else begin
         result = det;
      end
      return result;
   endfunction

   function automatic fillLevels_t fillOf(int p0, int p1, int p2, int p3, int p4);
      fillLevels_t fill;
      fill[0] = fillLevel_t'(p0);
      fill[1] = fillLevel_t'(p1);
      fill[2] = fillLevel_t'(p2);
      fill[3] = fillLevel_t'(p3);
      fill[4] = fillLevel_t'(p4);
      return fill;
   endfunction

   function automatic fillLevels_t randomFill();
      fillLevels_t fill;
      for (int p = 0; p < numPorts; p++) begin
         fill[p] = fillLevel_t'($urandom_range(0, 255));
      end
      return fill;
   endfunction

   task automatic addRow(string name, ctrlWord_t ctrl, fillLevels_t fill, irqVector_t det);
      rowName.push_back(name);
      rowCtrl.push_back(ctrl);
      rowFill.push_back(fill);
      rowDet.push_back(det);
      rowIrq.push_back(expectIrq(ctrl, fill, det));
      rowLed.push_back({4'hF, ~ctrl});  // Active low, upper LEDs dark
   endtask

   // Re-arm bit stays clear so the reset sequencer is left alone
   task automatic buildTable();
      addRow("burst levels 0 127 128 255", 4'b0001, fillOf(0, 127, 128, 255, 127), 8'h00);
      addRow("burst all empty", 4'b0001, fillOf(0, 0, 0, 0, 0), 8'hFF);
      addRow("burst all at threshold", 4'b0101, fillOf(128, 128, 128, 128, 128), 8'hFF);
      addRow("burst all full", 4'b1001, fillOf(255, 255, 255, 255, 255), 8'h00);
      addRow("burst edges swapped", 4'b1101, fillOf(128, 127, 255, 0, 128), 8'hE0);
      for (int n = 0; n < 4; n++) begin
         addRow($sformatf("burst random %0d", n), 4'b0001 | ctrlWord_t'(n << 2),
                randomFill(), irqVector_t'($urandom_range(0, 255)));
      end
      addRow("idle detector init a5", 4'b0000, randomFill(), 8'hA5);
      addRow("idle detector init ff", 4'b1100, randomFill(), 8'hFF);
      addRow("idle detector init 00", 4'b0100, fillOf(0, 0, 0, 0, 0), 8'h00);
      addRow("idle detector init 5a", 4'b1000, randomFill(), 8'h5A);
      addRow("idle detector init 1f", 4'b0000, fillOf(0, 0, 0, 0, 0), 8'h1F);
   endtask

   //========================================
   // Test sequences
   //========================================
   // Starts at a falling edge where the high phase has begun
   task automatic measureResetSequence(string name);
      int highCycles;
      int lowCycles;
      highCycles = 0;
      lowCycles  = 0;
      while (softResetN === 1'b1 && highCycles < seqLimit) begin
         highCycles++;
         @(negedge OSC_50_BANK6);
      end
      while (softResetN === 1'b0 && lowCycles < seqLimit) begin
         lowCycles++;
         @(negedge OSC_50_BANK6);
      end
      checkCount({name, " hold-off cycles"}, holdOffCycles + 1, highCycles);
      checkCount({name, " pulse cycles"}, pulseCycles, lowCycles);
      // Waiting state keeps the cores out of reset for a whole sequence length
      for (int k = 0; k < holdOffCycles + pulseCycles; k++) begin
         checkLevel($sformatf("%s released cycle %0d", name, k), 8'h01,
                    {7'b0, softResetN});
         @(negedge OSC_50_BANK6);
      end
   endtask

   task automatic applyTable();
      for (int r = 0; r < rowName.size(); r++) begin
         ctrlWord          = rowCtrl[r];
         fillLevels        = rowFill[r];
         detectorUnderInit = rowDet[r];
         repeat (settleCycles) @(negedge OSC_50_BANK6);
         checkIrq(rowName[r], rowIrq[r], interrupt);
         checkLevel({rowName[r], " LED"}, rowLed[r], LED);
      end
   endtask

   // Marker shows one cycle after the edge pulse, which lags ctrlWord by one
   task automatic checkMarkerWindow(string name, ctrlWord_t ctrl, markerPair_t active);
      markerPair_t expected;
      ctrlWord = ctrl;
      for (int k = 1; k <= markerCycles + 2; k++) begin
         @(negedge OSC_50_BANK6);
         if (k >= 2 && k <= markerCycles + 1) begin
            expected = active;
         end else begin
            expected = '0;
         end
         checkMarkers($sformatf("%s cycle %0d", name, k), expected, markerPins());
      end
   endtask

   //========================================
   // Main sequence
   //========================================
   initial begin
      markerPair_t startMark;
      markerPair_t endMark;
      void'($urandom(randomSeed));
      reset             = 1'b1;
      ctrlWord          = '0;
      fillLevels        = '0;
      detectorUnderInit = '0;
      buildTable();

      repeat (resetCycles) @(negedge OSC_50_BANK6);
      reset = 1'b0;

      checkIrq("after reset interrupt", '0, interrupt);
      checkMarkers("after reset markers", '0, markerPins());
      checkLevel("after reset softResetN", 8'h01, {7'b0, softResetN});
      checkLevel("after reset LED", 8'hFF, LED);
      measureResetSequence("power-up");

      applyTable();

      startMark.ecrst = 1'b1;  // Start of burst
      startMark.bcrst = 1'b1;
      endMark.ecrst   = 1'b1;  // End of burst
      endMark.bcrst   = 1'b0;
      checkMarkerWindow("burst start marker", 4'b0001, startMark);
      checkMarkerWindow("burst end marker", 4'b0000, endMark);

      // One-cycle re-arm pulse, sequence restarts two cycles later
      ctrlWord = 4'b0010;
      @(negedge OSC_50_BANK6);
      ctrlWord = 4'b0000;
      @(negedge OSC_50_BANK6);
      measureResetSequence("re-arm");

      $display("All checks passed");
      $finish;
   end

   // Watchdog sized from the table length
   initial begin
      int limit;
      @(negedge OSC_50_BANK6);
      limit = rowName.size() * 8 + 200;
      repeat (limit) @(posedge OSC_50_BANK6);
      reportFailure("Timeout: the test sequence did not finish in the allowed number of cycles");
   end

endmodule

// ==== src/l0TribeBoard.sv ====
// Top level of the board controller; sets the timing parameters and wires the four blocks together
module l0TribeBoard
   import tribePkg::*;
#(
   parameter int unsigned RefillThreshold  = 128,
   parameter int unsigned MarkerCycles     = 4,
   parameter int unsigned HoldOffCycles    = 200000,
   parameter int unsigned ResetPulseCycles = 65000000
) (
   input  logic        OSC_50_BANK6,
   input  logic        reset,
   input  ctrlWord_t   ctrlWord,           // From the embedded processor
   input  fillLevels_t fillLevels,         // Primitive buffer used words
   input  irqVector_t  detectorUnderInit,
   output irqVector_t  interrupt,          // To the embedded processor
   output logic        ECRST,
   output logic        BCRST,
   output logic        softResetN,         // For the processor and buffer cores
   output logic [7:0]  LED
);

   burstCtrl_t  burstCtrl;
   markerPair_t markers;

   //========================================
   // Control decode
   //========================================
   controlDecoder controlDecoder_i (
      .OSC_50_BANK6 (OSC_50_BANK6),
      .reset        (reset),
      .ctrlWord     (ctrlWord),
      .burstCtrl    (burstCtrl),
      .LED          (LED)
   );

   //========================================
   // Execute side
   //========================================
   refillRequester #(
      .RefillThreshold (RefillThreshold)
   ) refillRequester_i (
      .OSC_50_BANK6      (OSC_50_BANK6),
      .reset             (reset),
      .burstCtrl         (burstCtrl),
      .fillLevels        (fillLevels),
      .detectorUnderInit (detectorUnderInit),
      .interrupt         (interrupt)
   );

   burstMarkerDispatcher #(
      .MarkerCycles (MarkerCycles)
   ) burstMarkerDispatcher_i (
      .OSC_50_BANK6 (OSC_50_BANK6),
      .reset        (reset),
      .burstCtrl    (burstCtrl),
      .markers      (markers)
   );

   softResetSequencer #(
      .HoldOffCycles    (HoldOffCycles),
      .ResetPulseCycles (ResetPulseCycles)
   ) softResetSequencer_i (
      .OSC_50_BANK6 (OSC_50_BANK6),
      .reset        (reset),
      .burstCtrl    (burstCtrl),
      .softResetN   (softResetN)
   );

   // Marker pins on the JP3 connector
   assign ECRST = markers.ecrst;
   assign BCRST = markers.bcrst;

endmodule

// ==== src/softResetSequencer.sv ====
// Generates the software reset for the surrounding cores; hold-off, low pulse, then wait for re-arm
module softResetSequencer
   import tribePkg::*;
#(
   parameter int unsigned HoldOffCycles    = 200000,
   parameter int unsigned ResetPulseCycles = 65000000
) (
   input  logic       OSC_50_BANK6,
   input  logic       reset,
   input  burstCtrl_t burstCtrl,
   output logic       softResetN
);

   localparam int unsigned maxCount =
      (HoldOffCycles > ResetPulseCycles) ? HoldOffCycles : ResetPulseCycles;
   localparam int countWidth = $clog2(maxCount + 1);

   localparam logic [countWidth-1:0] holdOffLast = countWidth'(HoldOffCycles - 1);
   localparam logic [countWidth-1:0] pulseLast   = countWidth'(ResetPulseCycles - 1);

   typedef enum logic [1:0] {
      stClear,    // One cycle to clear the counter
      stHoldOff,  // Cores run before the pulse
      stPulse,    // Reset asserted
      stWait      // Idle until re-armed
   } seqState_t;

   seqState_t             state;
   logic [countWidth-1:0] count;  // Shared by hold-off and pulse

   //========================================
   // Sequencer FSM
   //========================================
   always_ff @(posedge OSC_50_BANK6) begin
      if (reset) begin
         state <= stClear;
         count <= '0;
      end else begin
         case (state)
            stClear: begin
               count <= '0;
               state <= stHoldOff;
            end
            stHoldOff: begin
               if (count == holdOffLast) begin
                  count <= '0;
                  state <= stPulse;
               end else begin
                  count <= count + 1'b1;
               end
            end
            stPulse: begin
               if (count == pulseLast) begin
                  count <= '0;
                  state <= stWait;
               end else begin
                  count <= count + 1'b1;
               end
            end
            stWait: begin
               if (burstCtrl.resetRearm) state <= stClear;  // Run the whole sequence again
            end
            default: state <= stClear;
         endcase
      end
   end

   assign softResetN = (state != stPulse);  // Active low, only in the pulse state

endmodule

// ==== src/burstMarkerDispatcher.sv ====
// Drives the start and end of burst markers ECRST and BCRST for a fixed number of cycles
module burstMarkerDispatcher
   import tribePkg::*;
#(
   parameter int unsigned MarkerCycles = 4
) (
   input  logic        OSC_50_BANK6,
   input  logic        reset,
   input  burstCtrl_t  burstCtrl,
   output markerPair_t markers
);

   localparam int countWidth = (MarkerCycles > 1) ? $clog2(MarkerCycles) : 1;
   localparam logic [countWidth-1:0] lastCount = countWidth'(MarkerCycles - 1);

   logic [countWidth-1:0] remaining;   // Cycles left after the current one
   logic                  active;      // Marker on the pins
   logic                  startKind;   // 1 for start of burst, 0 for end
   logic                  anyEdge;

   assign anyEdge = burstCtrl.burstStart | burstCtrl.burstEnd;

   //========================================
   // Marker timer
   //========================================
   always_ff @(posedge OSC_50_BANK6) begin
      if (reset) begin
         remaining <= '0;
         active    <= 1'b0;
         startKind <= 1'b0;
      end else if (anyEdge) begin
         // A new edge restarts the marker, even mid-pulse
         remaining <= lastCount;
         active    <= 1'b1;
         startKind <= burstCtrl.burstStart;
      end else if (active) begin
         if (remaining == '0) begin
            active <= 1'b0;  // Length used up
         end else begin
            remaining <= remaining - 1'b1;
         end
      end
   end

   // ECRST marks both edges, BCRST only the start
   always_comb begin
      markers.ecrst = active;
      markers.bcrst = active & startKind;
   end

endmodule

// ==== src/refillRequester.sv ====
// Builds the refill interrupt vector for the processor from buffer fill levels and burst state
module refillRequester
   import tribePkg::*;
#(
   parameter int unsigned RefillThreshold = 128
) (
   input  logic        OSC_50_BANK6,
   input  logic        reset,
   input  burstCtrl_t  burstCtrl,
   input  fillLevels_t fillLevels,
   input  irqVector_t  detectorUnderInit,
   output irqVector_t  interrupt
);

   logic [numPorts-1:0] belowThreshold;  // One request per buffer
   irqVector_t          irqNext;

   //========================================
   // Threshold compare
   //========================================
   // A buffer running low asks the processor for more primitives
   always_comb begin
      for (int port = 0; port < numPorts; port++) begin
         belowThreshold[port] = (fillLevels[port] < RefillThreshold);
      end
   end

   // Burst selects refill requests, otherwise detector init flags
   always_comb begin
      if (burstCtrl.inBurst) begin
         irqNext = {{(irqWidth - numPorts){1'b0}}, belowThreshold};
      end else begin
         irqNext = detectorUnderInit;
      end
   end

   //========================================
   // Output register
   //========================================
   always_ff @(posedge OSC_50_BANK6) begin
      if (reset) begin
         interrupt <= '0;
      end else begin
         interrupt <= irqNext;  // Seen by the processor one cycle later
      end
   end

endmodule

// ==== src/controlDecoder.sv ====
// Registers the processor control word and derives burst level, burst edges, re-arm and LEDs
module controlDecoder
   import tribePkg::*;
(
   input  logic       OSC_50_BANK6,
   input  logic       reset,
   input  ctrlWord_t  ctrlWord,
   output burstCtrl_t burstCtrl,
   output logic [7:0] LED
);

   localparam int ledWidth = 8;

   ctrlWord_t ctrlReg;     // Last control word seen
   logic      prevBurst;   // Burst level one cycle back
   logic      burstLevel;

   //========================================
   // Control word capture
   //========================================
   always_ff @(posedge OSC_50_BANK6) begin
      if (reset) begin
         ctrlReg   <= '0;
         prevBurst <= 1'b0;
      end else begin
         ctrlReg   <= ctrlWord;
         prevBurst <= burstLevel;
      end
   end

   assign burstLevel = ctrlReg[burstBit];

   // Edges show up in the same cycle as the new level
   always_comb begin
      burstCtrl.inBurst    = burstLevel;
      burstCtrl.burstStart = burstLevel & ~prevBurst;
      burstCtrl.burstEnd   = ~burstLevel & prevBurst;
      burstCtrl.resetRearm = ctrlReg[resetBit];
   end

   //========================================
   // Status LEDs
   //========================================
   // LEDs are lit by a low level
   // Low nibble mirrors the control bits, upper LEDs stay dark
   assign LED = {{(ledWidth - ctrlWidth){1'b1}}, ~ctrlReg};

endmodule

// ==== src/tribePkg.sv ====
// Shared widths, control-bit positions and packed types; imported by every board controller module
package tribePkg;

   //========================================
   // Sizes
   //========================================
   localparam int numPorts  = 5;  // One primitive buffer per port
   localparam int fillWidth = 8;  // Write-side used-word count
   localparam int ctrlWidth = 4;  // Control word from the processor
   localparam int irqWidth  = 8;  // Interrupt and detector-init vectors

   // Control word bit positions
   localparam int burstBit = 0;   // Burst level
   localparam int resetBit = 1;   // Software reset re-arm

   //========================================
   // Types
   //========================================
   typedef logic [fillWidth-1:0] fillLevel_t;

   // All buffer fill levels, port 0 in the low byte
   typedef fillLevel_t [numPorts-1:0] fillLevels_t;

   typedef logic [ctrlWidth-1:0] ctrlWord_t;

   typedef logic [irqWidth-1:0] irqVector_t;

   // Decoded control word, shared by all execute-side blocks
   typedef struct packed {
      logic inBurst;     // Registered burst level
      logic burstStart;  // One cycle on the rising edge of inBurst
      logic burstEnd;    // One cycle on the falling edge of inBurst
      logic resetRearm;  // Registered re-arm level
   } burstCtrl_t;

   // Start of burst is ecrst=1 bcrst=1
   // End of burst is ecrst=1 bcrst=0
   typedef struct packed {
      logic ecrst;
      logic bcrst;
   } markerPair_t;

endpackage
